// ==== verilog/mem_subsys_pkg.sv ====
`default_nettype none

package mem_subsys_pkg;

  // ********************
  // memory and window geometry.
  // ********************
  localparam int mem_words = 1024;
  localparam int word_idx_w = $clog2(mem_words);
  localparam logic [19:0] mmio_page = 20'haaaaa;

  // register offsets inside the peripheral window.
  localparam logic [11:0] disp_offset = 12'h008;
  localparam logic [11:0] uart_base = 12'h400;
  localparam logic [11:0] uart_bytes = 12'h008;
  localparam logic [11:0] spi_data_offset = 12'h500;
  localparam logic [11:0] spi_stat_offset = 12'h501;
  localparam logic [11:0] cfg_base = 12'h600;
  localparam logic [11:0] cfg_last = 12'h61c;
  localparam logic [11:0] cnt_value_offset = 12'h700;
  localparam logic [11:0] cnt_clear_offset = 12'h704;

  // store width, word is also the accelerator write width.
  typedef enum logic [2:0] {
    st_byte = 3'b001,
    st_half = 3'b010,
    st_word = 3'b100
  } store_ctrl_e;

  // one address, read as a window offset or as a ram word index.
  typedef union packed {
    struct packed {
      logic [19:0] page;
      logic [11:0] offset;
    } mmio_view;
    struct packed {
      logic [1:0]            region;
      logic [27-word_idx_w:0] unused;
      logic [word_idx_w-1:0] word_idx;
      logic [1:0]            byte_off;
    } mem_view;
  } bus_addr_u;

  typedef struct packed {
    bus_addr_u   addr;
    logic [31:0] wdata;
    logic        rea;
    logic        wea;
    logic [3:0]  be;
    store_ctrl_e store_ctrl;
  } cpu_req_s;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        rd;
    logic        wr;
  } aux_req_s;

  typedef struct packed {
    logic [word_idx_w-1:0] word_idx;
    logic [31:0]           wdata;
    logic [3:0]            wen;
    logic                  en;
  } ram_req_s;

  typedef struct packed {
    logic [7:0] uart_dout;
    logic [7:0] spi_dout;
    logic       spi_full;
    logic       spi_empty;
    logic       spi_avail;
  } periph_stat_s;

  // one-hot source of the read data returned next cycle.
  typedef struct packed {
    logic ram;
    logic uart;
    logic spi_data;
    logic spi_stat;
    logic cnt_value;
    logic cnt_ovflw;
  } read_src_s;

endpackage : mem_subsys_pkg

`default_nettype wire

// ==== verilog/request_router.sv ====
`default_nettype none

module request_router
  import mem_subsys_pkg::*;
(
  input  cpu_req_s    cpu_req,
  input  aux_req_s    aux_req,
  output logic        aux_rdy,
  output ram_req_s    ram_req,
  output read_src_s   read_src,
  output logic        cnt_clear,
  output logic        tx_wen,
  output logic        rx_ren,
  output logic [7:0]  uart_din,
  output logic [2:0]  uart_addr,
  output logic        spi_wr,
  output logic        spi_rd,
  output logic [7:0]  spi_din,
  output logic        spi_ignore,
  output logic        disp_wea,
  output logic [31:0] disp_dat,
  output logic        cfg_wr,
  output logic [2:0]  cfg_addr,
  output logic [31:0] cfg_din
);

  logic        cpu_act;
  logic        mmio_hit;
  logic        writable;
  logic [11:0] offset;
  logic        uart_hit;
  logic        spi_hit;
  logic        cfg_hit;
  logic        disp_hit;
  logic        cnt_hit;

  // lane mask of a store, placed at its byte offset.
  function automatic logic [3:0] lane_mask(store_ctrl_e ctrl, logic [1:0] off);
    case (ctrl)
      st_byte: lane_mask = 4'b0001 << off;
      st_half: lane_mask = 4'b0011 << {off[1], 1'b0};
      st_word: lane_mask = 4'b1111;
      default: lane_mask = 4'b0000;
    endcase
  endfunction

  assign cpu_act  = cpu_req.rea | cpu_req.wea;
  assign aux_rdy  = ~cpu_act;
  assign offset   = cpu_req.addr.mmio_view.offset;
  assign mmio_hit = (cpu_req.addr.mmio_view.page == mmio_page);
  assign writable = (cpu_req.addr.mem_view.region == 2'b00);

  // ********************
  // window decode.
  // ********************
  assign uart_hit = mmio_hit && (offset >= uart_base) && (offset < uart_base + uart_bytes);
  assign spi_hit  = mmio_hit && ((offset == spi_data_offset) || (offset == spi_stat_offset));
  assign cfg_hit  = mmio_hit && (offset >= cfg_base) && (offset <= cfg_last);
  assign disp_hit = mmio_hit && (offset == disp_offset);
  assign cnt_hit  = mmio_hit && (offset == cnt_clear_offset);

  // cpu owns the ram whenever it strobes.
  always_comb begin
    if (cpu_act) begin
      ram_req.word_idx = cpu_req.addr.mem_view.word_idx;
      ram_req.wdata    = cpu_req.wdata;
      ram_req.wen      = (cpu_req.wea && writable) ?
                         (cpu_req.be & lane_mask(cpu_req.store_ctrl,
                                                 cpu_req.addr.mem_view.byte_off)) : 4'b0000;
      ram_req.en       = ~mmio_hit;
    end else begin
      ram_req.word_idx = aux_req.addr[word_idx_w+1:2];
      ram_req.wdata    = aux_req.wdata;
      ram_req.wen      = aux_req.wr ? lane_mask(st_word, 2'b00) : 4'b0000;
      ram_req.en       = aux_req.rd | aux_req.wr;
    end
  end

  always_comb begin
    read_src.ram       = cpu_req.rea & ~mmio_hit;
    read_src.uart      = cpu_req.rea & uart_hit;
    read_src.spi_data  = cpu_req.rea & mmio_hit & (offset == spi_data_offset);
    read_src.spi_stat  = cpu_req.rea & mmio_hit & (offset == spi_stat_offset);
    read_src.cnt_value = cpu_req.rea & mmio_hit & (offset == cnt_value_offset);
    read_src.cnt_ovflw = cpu_req.rea & cnt_hit;
  end

  // ********************
  // peripheral strobes.
  // ********************
  assign tx_wen     = cpu_req.wea & uart_hit;
  assign rx_ren     = cpu_req.rea & uart_hit;
  assign uart_din   = cpu_req.wdata[7:0];
  assign uart_addr  = offset[2:0];
  assign spi_wr     = cpu_req.wea & spi_hit;
  assign spi_rd     = cpu_req.rea & spi_hit;
  assign spi_din    = cpu_req.wdata[7:0];
  assign spi_ignore = cpu_req.wdata[8];
  assign disp_wea   = cpu_req.wea & disp_hit;
  assign disp_dat   = cpu_req.wdata;
  assign cfg_wr     = cpu_req.wea & cfg_hit;
  assign cfg_addr   = offset[4:2];
  assign cfg_din    = cpu_req.wdata;
  assign cnt_clear  = cpu_req.wea & cnt_hit;

endmodule : request_router

`default_nettype wire

// ==== verilog/shared_block_ram.sv ====
`default_nettype none

module shared_block_ram
  import mem_subsys_pkg::*;
(
  input  logic        clk,
  input  ram_req_s    ram_req,
  output logic [31:0] rdata,
  input  logic        imem_en,
  input  logic [31:0] imem_addr,
  output logic [31:0] imem_rdata
);

  logic [31:0]           mem [mem_words];
  logic [31:0]           merged;
  logic [word_idx_w-1:0] imem_idx;

  assign imem_idx = imem_addr[word_idx_w+1:2];

  // stored word with the enabled lanes replaced.
  always_comb begin
    merged = mem[ram_req.word_idx];
    for (int b = 0; b < 4; b++) begin
      if (ram_req.wen[b]) begin
        merged[8*b +: 8] = ram_req.wdata[8*b +: 8];
      end
    end
  end

  // ********************
  // data port, write first.
  // ********************
  always_ff @(posedge clk) begin
    if (ram_req.en) begin
      if (|ram_req.wen) begin
        mem[ram_req.word_idx] <= merged;
      end
      rdata <= merged;
    end
  end

  // instruction port, read only.
  always_ff @(posedge clk) begin
    if (imem_en) begin
      imem_rdata <= mem[imem_idx];
    end
  end

endmodule : shared_block_ram

`default_nettype wire

// ==== verilog/cycle_counter.sv ====
`default_nettype none

module cycle_counter (
  input  logic        clk,
  input  logic        rst,
  input  logic        clear,
  output logic [31:0] count,
  output logic        ovflw
);

  logic wrap;

  // all ones now, zero after this edge.
  assign wrap = &count;

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
      ovflw <= 1'b0;
    end else if (clear) begin
      count <= '0;
      ovflw <= 1'b0;
    end else begin
      count <= count + 32'd1;
      if (wrap) begin
        ovflw <= 1'b1;
      end
    end
  end

endmodule : cycle_counter

`default_nettype wire

// ==== verilog/read_return_mux.sv ====
`default_nettype none

module read_return_mux
  import mem_subsys_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  read_src_s    read_src,
  input  logic [31:0]  ram_rdata,
  input  periph_stat_s periph,
  input  logic [31:0]  count,
  input  logic         ovflw,
  input  logic         aux_sel,
  output logic [31:0]  cpu_rdata,
  output logic [31:0]  aux_rdata
);

  read_src_s   src_q;
  logic [31:0] capt_d;
  logic [31:0] capt_q;
  logic        periph_q;

  // ********************
  // capture at the read strobe.
  // ********************
  always_comb begin
    capt_d = capt_q;
    if (read_src.uart) begin
      capt_d = {24'h0, periph.uart_dout};
    end else if (read_src.spi_data) begin
      capt_d = {24'h0, periph.spi_dout};
    end else if (read_src.spi_stat) begin
      capt_d = {29'h0, periph.spi_full, periph.spi_empty, periph.spi_avail};
    end else if (read_src.cnt_value) begin
      capt_d = count;
    end else if (read_src.cnt_ovflw) begin
      capt_d = {31'h0, ovflw};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      src_q <= '0;
    end else if (aux_sel) begin
      // accelerator cycle, nothing comes back to the cpu.
      src_q <= '0;
    end else begin
      src_q <= read_src;
    end
  end

  always_ff @(posedge clk) begin
    capt_q <= capt_d;
  end

  // ********************
  // return path.
  // ********************
  assign periph_q = src_q.uart | src_q.spi_data | src_q.spi_stat |
                    src_q.cnt_value | src_q.cnt_ovflw;

  always_comb begin
    if (src_q.ram) begin
      cpu_rdata = ram_rdata;
    end else if (periph_q) begin
      cpu_rdata = capt_q;
    end else begin
      cpu_rdata = '0;
    end
  end

  assign aux_rdata = ram_rdata;

endmodule : read_return_mux

`default_nettype wire

// ==== verilog/mem_controller.sv ====
`default_nettype none

module mem_controller
  import mem_subsys_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  cpu_req_s     cpu_req,
  output logic [31:0]  cpu_rdata,
  input  aux_req_s     aux_req,
  output logic         aux_rdy,
  output logic [31:0]  aux_rdata,
  input  logic         imem_en,
  input  logic [31:0]  imem_addr,
  output logic [31:0]  imem_rdata,
  input  periph_stat_s periph,
  output logic         tx_wen,
  output logic         rx_ren,
  output logic [7:0]   uart_din,
  output logic [2:0]   uart_addr,
  output logic         spi_wr,
  output logic         spi_rd,
  output logic [7:0]   spi_din,
  output logic         spi_ignore,
  output logic         disp_wea,
  output logic [31:0]  disp_dat,
  output logic         cfg_wr,
  output logic [2:0]   cfg_addr,
  output logic [31:0]  cfg_din
);

  ram_req_s    ram_req;
  read_src_s   read_src;
  logic        cnt_clear;
  logic [31:0] ram_rdata;
  logic [31:0] count;
  logic        ovflw;

  request_router request_router_i (
    .cpu_req    (cpu_req),
    .aux_req    (aux_req),
    .aux_rdy    (aux_rdy),
    .ram_req    (ram_req),
    .read_src   (read_src),
    .cnt_clear  (cnt_clear),
    .tx_wen     (tx_wen),
    .rx_ren     (rx_ren),
    .uart_din   (uart_din),
    .uart_addr  (uart_addr),
    .spi_wr     (spi_wr),
    .spi_rd     (spi_rd),
    .spi_din    (spi_din),
    .spi_ignore (spi_ignore),
    .disp_wea   (disp_wea),
    .disp_dat   (disp_dat),
    .cfg_wr     (cfg_wr),
    .cfg_addr   (cfg_addr),
    .cfg_din    (cfg_din)
  );

  shared_block_ram shared_block_ram_i (
    .clk        (clk),
    .ram_req    (ram_req),
    .rdata      (ram_rdata),
    .imem_en    (imem_en),
    .imem_addr  (imem_addr),
    .imem_rdata (imem_rdata)
  );

  cycle_counter cycle_counter_i (
    .clk   (clk),
    .rst   (rst),
    .clear (cnt_clear),
    .count (count),
    .ovflw (ovflw)
  );

  // aux_rdy high means the ram belongs to the accelerator.
  read_return_mux read_return_mux_i (
    .clk       (clk),
    .rst       (rst),
    .read_src  (read_src),
    .ram_rdata (ram_rdata),
    .periph    (periph),
    .count     (count),
    .ovflw     (ovflw),
    .aux_sel   (aux_rdy),
    .cpu_rdata (cpu_rdata),
    .aux_rdata (aux_rdata)
  );

endmodule : mem_controller

`default_nettype wire

// ==== dv/mem_subsys_assertions.sv ====
`default_nettype none

module mem_subsys_assertions
  import mem_subsys_pkg::*;
(
  input logic     clk,
  input logic     rst,
  input cpu_req_s cpu_req,
  input logic     aux_rdy,
  input ram_req_s ram_req,
  input logic     tx_wen,
  input logic     rx_ren,
  input logic     spi_wr,
  input logic     spi_rd,
  input logic     disp_wea,
  input logic     cfg_wr
);
  timeunit 1ns;
  timeprecision 1ps;

  // accelerator gets the ram only in idle cpu cycles.
  aux_blocked: assert property (@(posedge clk) disable iff (rst)
    (cpu_req.rea || cpu_req.wea) |-> !aux_rdy)
    else $error("aux_rdy high during a cpu access");

  write_strobes: assert property (@(posedge clk) disable iff (rst)
    (tx_wen || spi_wr || disp_wea || cfg_wr) |-> cpu_req.wea)
    else $error("peripheral write strobe without cpu write");

  read_strobes: assert property (@(posedge clk) disable iff (rst)
    (rx_ren || spi_rd) |-> cpu_req.rea)
    else $error("peripheral read strobe without cpu read");

  // protected region.
  write_protect: assert property (@(posedge clk) disable iff (rst)
    (cpu_req.wea && (cpu_req.addr.mem_view.region != 2'b00)) |-> (ram_req.wen == 4'b0000))
    else $error("ram write enabled outside the writable region");

endmodule : mem_subsys_assertions

`default_nettype wire

// ==== dv/tb_mem_subsys.sv ====
`default_nettype none

module tb_mem_subsys
  import mem_subsys_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  typedef enum logic [2:0] {op_idle, op_wr, op_rd, op_rdx, op_ird} op_e;
  typedef enum logic [1:0] {acc_none, acc_rd, acc_wr} acc_e;

  typedef struct packed {
    op_e         op;
    logic [31:0] addr;
    logic [31:0] data;
    store_ctrl_e width;
    acc_e        acc;
    logic [31:0] acc_addr;
    logic [31:0] acc_data;
    logic [31:0] exp;
  } row_s;

  logic clk = 1'b0;
  logic rst = 1'b1;
  cpu_req_s cpu_req = '0;
  aux_req_s aux_req = '0;
  logic imem_en = 1'b0;
  logic [31:0] imem_addr = '0;
  periph_stat_s periph = '0;
  logic [31:0] cpu_rdata, aux_rdata, imem_rdata, disp_dat, cfg_din;
  logic aux_rdy, tx_wen, rx_ren, spi_wr, spi_rd, spi_ignore, disp_wea, cfg_wr;
  logic [7:0] uart_din, spi_din;
  logic [2:0] uart_addr, cfg_addr;

  row_s rows[$];
  logic [7:0] ref_mem [4*mem_words];
  logic exp_cpu_valid, exp_aux_valid, exp_imem_valid;
  logic [31:0] exp_cpu, exp_aux, exp_imem;
  int limit;

  mem_controller mem_controller_i (.*);

  bind mem_controller mem_subsys_assertions mem_subsys_assertions_i (
    .clk(clk), .rst(rst), .cpu_req(cpu_req), .aux_rdy(aux_rdy), .ram_req(ram_req),
    .tx_wen(tx_wen), .rx_ren(rx_ren), .spi_wr(spi_wr), .spi_rd(spi_rd),
    .disp_wea(disp_wea), .cfg_wr(cfg_wr)
  );

  always #10 clk = ~clk;

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
      $display("Test failures found");
      $fatal(1, "check mismatch");
    end
  endtask

  // bytes of one word from the reference memory.
  function automatic logic [31:0] ref_word(input logic [31:0] addr);
    int a;
    a = {20'h0, addr[11:2], 2'b00};
    return {ref_mem[a+3], ref_mem[a+2], ref_mem[a+1], ref_mem[a]};
  endfunction

  // byte lanes touched by a store.
  function automatic logic [3:0] store_lanes(input store_ctrl_e w, input logic [1:0] off);
    if (w == st_byte) return 4'b0001 << off;
    if (w == st_half) return off[1] ? 4'b1100 : 4'b0011;
    return 4'b1111;
  endfunction

  function automatic void add_row(input op_e op, input logic [31:0] addr, input logic [31:0] data,
                                  input store_ctrl_e w, input acc_e acc,
                                  input logic [31:0] acc_addr, input logic [31:0] exp);
    row_s r;
    r = '{op, addr, data, w, acc, acc_addr, $urandom, exp};
    rows.push_back(r);
  endfunction

  // ********************
  // stimulus table.
  // ********************
  task automatic build_table();
    logic [31:0] spi_stat;
    spi_stat = {29'h0, periph.spi_full, periph.spi_empty, periph.spi_avail};
    for (int a = 0; a < 5; a++) begin
      add_row(op_wr, 32'(4 * a), $urandom, st_word, acc_none, 0, 0);
    end
    add_row(op_wr, 32'h001, $urandom, st_byte, acc_none, 0, 0);
    add_row(op_wr, 32'h006, $urandom, st_half, acc_none, 0, 0);
    add_row(op_wr, 32'h00b, $urandom, st_byte, acc_none, 0, 0);
    add_row(op_wr, 32'h00c, $urandom, st_half, acc_none, 0, 0);
    add_row(op_rd, 32'h000, 0, st_word, acc_none, 0, 0);
    add_row(op_rd, 32'h004, 0, st_word, acc_none, 0, 0);
    add_row(op_rd, 32'h008, 0, st_word, acc_none, 0, 0);
    add_row(op_idle, 0, 0, st_word, acc_none, 0, 0);
    add_row(op_rd, 32'h00c, 0, st_word, acc_none, 0, 0);
    add_row(op_idle, 0, 0, st_word, acc_none, 0, 0);
    add_row(op_idle, 0, 0, st_word, acc_none, 0, 0);
    add_row(op_rd, 32'h010, 0, st_word, acc_none, 0, 0);
    // writes outside the writable region.
    add_row(op_wr, 32'h4000_0010, $urandom, st_word, acc_none, 0, 0);
    add_row(op_wr, 32'hc000_0004, $urandom, st_byte, acc_none, 0, 0);
    add_row(op_rd, 32'h010, 0, st_word, acc_none, 0, 0);
    add_row(op_rd, 32'h004, 0, st_word, acc_none, 0, 0);
    add_row(op_ird, 32'h010, 0, st_word, acc_none, 0, 0);
    add_row(op_ird, 32'h000, 0, st_word, acc_none, 0, 0);
    // accelerator in idle cycles, then one held behind a cpu read.
    add_row(op_idle, 0, 0, st_word, acc_wr, 32'h020, 0);
    add_row(op_idle, 0, 0, st_word, acc_rd, 32'h020, 0);
    add_row(op_rd, 32'h020, 0, st_word, acc_none, 0, 0);
    add_row(op_rd, 32'h020, 0, st_word, acc_wr, 32'h020, 0);
    rows.push_back(rows[rows.size()-1]);
    rows[rows.size()-1].op = op_idle;
    add_row(op_idle, 0, 0, st_word, acc_rd, 32'h020, 0);
    // peripheral window.
    add_row(op_wr, 32'haaaa_a008, $urandom, st_word, acc_none, 0, 0);
    add_row(op_wr, 32'haaaa_a403, $urandom, st_word, acc_none, 0, 0);
    add_row(op_rdx, 32'haaaa_a405, 0, st_word, acc_none, 0, {24'h0, periph.uart_dout});
    add_row(op_wr, 32'haaaa_a500, $urandom, st_word, acc_none, 0, 0);
    add_row(op_rdx, 32'haaaa_a500, 0, st_word, acc_none, 0, {24'h0, periph.spi_dout});
    add_row(op_rdx, 32'haaaa_a501, 0, st_word, acc_none, 0, spi_stat);
    add_row(op_wr, 32'haaaa_a614, $urandom, st_word, acc_none, 0, 0);
    add_row(op_wr, 32'haaaa_a61c, $urandom, st_word, acc_none, 0, 0);
    // a counter read k cycles after a clear returns k-1.
    add_row(op_wr, 32'haaaa_a704, 0, st_word, acc_none, 0, 0);
    add_row(op_idle, 0, 0, st_word, acc_none, 0, 0);
    add_row(op_idle, 0, 0, st_word, acc_none, 0, 0);
    add_row(op_rdx, 32'haaaa_a700, 0, st_word, acc_none, 0, 32'd2);
    add_row(op_wr, 32'haaaa_a704, 0, st_word, acc_none, 0, 0);
    add_row(op_rdx, 32'haaaa_a700, 0, st_word, acc_none, 0, 32'd0);
    add_row(op_rdx, 32'haaaa_a704, 0, st_word, acc_none, 0, 32'd0);
  endtask

  task automatic apply_row(input row_s r);
    logic cpu_act;
    logic [3:0] lanes;
    int base;
    cpu_act = (r.op == op_wr) || (r.op == op_rd) || (r.op == op_rdx);
    lanes = store_lanes(r.width, r.addr[1:0]);
    cpu_req.addr = r.addr;
    cpu_req.wdata = r.data;
    cpu_req.wea = (r.op == op_wr);
    cpu_req.rea = (r.op == op_rd) || (r.op == op_rdx);
    cpu_req.be = lanes;
    cpu_req.store_ctrl = r.width;
    aux_req.addr = r.acc_addr;
    aux_req.wdata = r.acc_data;
    aux_req.rd = (r.acc == acc_rd);
    aux_req.wr = (r.acc == acc_wr);
    imem_en = (r.op == op_ird);
    imem_addr = r.addr;
    exp_cpu_valid = cpu_req.rea;
    exp_cpu = (r.op == op_rdx) ? r.exp : ref_word(r.addr);
    exp_imem_valid = imem_en;
    exp_imem = ref_word(r.addr);
    exp_aux_valid = !cpu_act && (r.acc == acc_rd);
    exp_aux = ref_word(r.acc_addr);
    base = {20'h0, r.addr[11:2], 2'b00};
    if (cpu_req.wea && r.addr[31:30] == 2'b00) begin
      for (int b = 0; b < 4; b++) begin
        if (lanes[b]) ref_mem[base+b] = r.data[8*b +: 8];
      end
    end
    base = {20'h0, r.acc_addr[11:2], 2'b00};
    if (!cpu_act && r.acc == acc_wr) begin
      for (int b = 0; b < 4; b++) begin
        ref_mem[base+b] = r.acc_data[8*b +: 8];
      end
    end
  endtask

  // combinational strobes and fields of the current row.
  task automatic check_strobes(input row_s r);
    logic [11:0] off;
    logic win, wr, rd;
    logic [5:0] exp_vec;
    off = r.addr[11:0];
    win = (r.addr[31:12] == mmio_page);
    wr = (r.op == op_wr);
    rd = (r.op == op_rd) || (r.op == op_rdx);
    exp_vec[5] = wr && win && off >= uart_base && off < uart_base + uart_bytes;
    exp_vec[4] = rd && win && off >= uart_base && off < uart_base + uart_bytes;
    exp_vec[3] = wr && win && (off == spi_data_offset || off == spi_stat_offset);
    exp_vec[2] = rd && win && (off == spi_data_offset || off == spi_stat_offset);
    exp_vec[1] = wr && win && off == disp_offset;
    exp_vec[0] = wr && win && off >= cfg_base && off <= cfg_last;
    check("aux_rdy", {31'h0, !(wr || rd)}, {31'h0, aux_rdy});
    check("strobes", {26'h0, exp_vec},
          {26'h0, tx_wen, rx_ren, spi_wr, spi_rd, disp_wea, cfg_wr});
    if (exp_vec[5] || exp_vec[4]) check("uart_addr", {29'h0, off[2:0]}, {29'h0, uart_addr});
    if (exp_vec[5]) check("uart_din", {24'h0, r.data[7:0]}, {24'h0, uart_din});
    if (exp_vec[3]) begin
      check("spi_din", {24'h0, r.data[7:0]}, {24'h0, spi_din});
      check("spi_ignore", {31'h0, r.data[8]}, {31'h0, spi_ignore});
    end
    if (exp_vec[1]) check("disp_dat", r.data, disp_dat);
    if (exp_vec[0]) begin
      check("cfg_addr", {29'h0, off[4:2]}, {29'h0, cfg_addr});
      check("cfg_din", r.data, cfg_din);
    end
  endtask

  task automatic check_results();
    if (exp_cpu_valid) check("cpu_rdata", exp_cpu, cpu_rdata);
    if (exp_aux_valid) check("aux_rdata", exp_aux, aux_rdata);
    if (exp_imem_valid) check("imem_rdata", exp_imem, imem_rdata);
  endtask

  initial begin
    void'($urandom(92655));
    periph.uart_dout = 8'($urandom);
    periph.spi_dout = 8'($urandom);
    periph.spi_full = 1'($urandom);
    periph.spi_empty = 1'($urandom);
    periph.spi_avail = 1'($urandom);
    build_table();
    limit = (rows.size() * 4 + 16) * 20;
    fork
      begin
        #(limit);
        $display("run hung, the table did not finish within %0d ns", limit);
        $display("Test failures found");
        $fatal(1, "watchdog expired");
      end
    join_none
    repeat (16) @(posedge clk);
    #2;
    check("cpu_rdata", 32'h0, cpu_rdata);
    rst = 1'b0;
    foreach (rows[i]) begin
      apply_row(rows[i]);
      #1;
      check_strobes(rows[i]);
      @(posedge clk);
      #2;
      check_results();
    end
    $display("All tests passed!");
    $finish;
  end

endmodule : tb_mem_subsys

`default_nettype wire

// ==== mem_subsys.f ====
verilog/mem_subsys_pkg.sv
verilog/request_router.sv
verilog/shared_block_ram.sv
verilog/cycle_counter.sv
verilog/read_return_mux.sv
verilog/mem_controller.sv
dv/mem_subsys_assertions.sv
dv/tb_mem_subsys.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the memory subsystem testbench with Verilator
rm -rf obj_dir sim.log && \
verilator --binary --timing --assert --top-module tb_mem_subsys \
  -f mem_subsys.f -o sim_mem_subsys && \
./obj_dir/sim_mem_subsys > sim.log 2>&1 || true
cat sim.log 2>/dev/null || true
grep -q "All tests passed!" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }
